// File: lcd_ctrl.f
hdl/lcd_pkg.sv
hdl/lcd_cmd_decode.sv
hdl/lcd_sequencer.sv
hdl/lcd_strobe_gen.sv
hdl/lcd_ctrl.sv
testbench/lcd_monitor.sv
testbench/lcd_ctrl_chk.sv
testbench/tb_lcd_ctrl.sv

// File: Makefile
# Verilator build and run of the lcd_ctrl testbench

TOP       ?= tb_lcd_ctrl
FLIST     ?= lcd_ctrl.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/tb_lcd_ctrl.sv
`timescale 1ns/100ps

module tb_lcd_ctrl import lcd_pkg::*; ();

	localparam int U        = 2; // clocks per microsecond
	localparam int INIT_CYC = (T_POWER_US + 2 * T_SHORT_US + T_CLEAR_US + T_ENTRY_US) * U + 4;
	localparam int LIMIT    = (INIT_CYC + 40 * (T_CLEAR_US * U + 1)) * 12 / 10;

	logic       clk;
	logic       arst_n;
	lcd_cfg_t   cfg;
	logic       lcd_enable;
	lcd_req_t   lcd_bus;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;
	logic       busy;
	int         cycles = 0;
	int         n_req  = 0; // accepted host requests

	lcd_ctrl #(
		.clk_per_us (U)
	) u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg        (cfg),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

	lcd_monitor #(
		.clk_per_us (U)
	) u_mon (
		.clk      (clk),
		.arst_n   (arst_n),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data),
		.busy     (busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: run still going after %0d cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// clear and return home need the long hold
	function automatic int expected_hold(input lcd_req_t r);
		if (!r.rs && !r.rw && (r.data == 8'h01 || r.data[7:1] == 7'h01))
			return T_CLEAR_US;
		return T_SHORT_US;
	endfunction

	function automatic lcd_cmd_t init_cmd(input int k, input lcd_cfg_t c);
		lcd_cmd_t r;
		r = '0;
		case (k)
			0: begin
				r.data    = {4'b0011, c.lines, c.font, 2'b00}; // function set
				r.hold_us = 9'(T_SHORT_US);
			end
			1: begin
				r.data    = {5'b00001, c.display, c.cursor, c.blink};
				r.hold_us = 9'(T_SHORT_US);
			end
			2: begin
				r.data    = 8'h01; // clear
				r.hold_us = 9'(T_CLEAR_US);
			end
			default: begin
				r.data    = {6'b000001, c.inc_dec, c.shift};
				r.hold_us = 9'(T_ENTRY_US);
			end
		endcase
		return r;
	endfunction

	task automatic wait_idle();
		@(posedge clk);
		#1;
		while (busy) begin
			@(posedge clk);
			#1;
		end
	endtask

	// one request, then stray strobes while the DUT is busy
	task automatic send_req(input lcd_req_t r, input int stray);
		lcd_cmd_t c;
		int       i;
		wait_idle();
		repeat ($urandom % 3) begin
			@(posedge clk);
			#1;
		end
		c = '{rs: r.rs, rw: r.rw, data: r.data, hold_us: 9'(expected_hold(r))};
		u_mon.push_cmd(c);
		u_mon.push_busy(expected_hold(r) * U + 1); // issue cycle plus the window
		lcd_bus    = r;
		lcd_enable = 1'b1;
		@(posedge clk);
		#1;
		lcd_enable = 1'b0;
		n_req++;
		for (i = 0; i < stray; i++) begin
			repeat (2 + $urandom % 20) @(posedge clk);
			#1;
			lcd_bus    = 10'($urandom);
			lcd_enable = 1'b1;
			@(posedge clk);
			#1;
			lcd_enable = 1'b0;
		end
	endtask

	initial begin
		lcd_cmd_t ic;
		lcd_req_t r;
		int       init_busy;
		int       k;
		int       end_errs;
		int       total;
		void'($urandom(98004));
		arst_n     = 1'b0;
		lcd_enable = 1'b0;
		lcd_bus    = '0;
		cfg        = 7'($urandom);
		end_errs   = 0;

		init_busy = T_POWER_US * U;
		for (k = 0; k < 4; k++) begin
			ic = init_cmd(k, cfg);
			u_mon.push_cmd(ic);
			init_busy += int'(ic.hold_us) * U + 1;
		end
		u_mon.push_busy(init_busy);

		repeat (5) @(posedge clk);
		#1 arst_n = 1'b1;

		for (k = 0; k < 20; k++) begin
			r = 10'($urandom);
			send_req(r, 0);
		end
		send_req({2'b00, 8'h01}, 0); // clear
		send_req({2'b00, 8'h02}, 0);
		send_req({2'b00, 8'h03}, 0);
		send_req({2'b00, 8'h04}, 0);
		send_req({2'b10, 8'h01}, 0); // data write, not a clear
		for (k = 0; k < 6; k++) begin
			r = 10'($urandom);
			send_req(r, 1 + k % 3);
		end

		wait_idle();
		repeat (5) @(posedge clk);
		#1;
		if (u_mon.pulse_cnt != n_req + 4) begin
			$display("Mismatch at %0t: %0d e pulses, expected %0d",
				$time, u_mon.pulse_cnt, n_req + 4);
			end_errs++;
		end
		if (u_mon.pending() != 0) begin
			$display("%0d expected bus events never showed up", u_mon.pending());
			end_errs++;
		end
		total = u_mon.err_cnt + u_dut.u_seq.u_chk.fail_cnt + end_errs;
		$display("errors: %0d total, %0d monitor, %0d assertion, %0d end of run",
			total, u_mon.err_cnt, u_dut.u_seq.u_chk.fail_cnt, end_errs);
		if (total == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: testbench/lcd_ctrl_chk.sv
`timescale 1ns/100ps

module lcd_ctrl_chk import lcd_pkg::*; #(
	parameter int clk_per_us = 10
) (
	input logic       clk,
	input logic       arst_n,
	input seq_state_e state,
	input logic       lcd_enable,
	input logic       issue,
	input logic       done,
	input logic       busy,
	input lcd_cmd_e   xfer_class
);

	int   fail_cnt = 0;
	logic in_win;  // strobe window open, e can only be high here
	int   win_cyc; // cycles since the last issue

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_win  <= 1'b0;
			win_cyc <= 0;
		end else if (issue) begin
			in_win  <= 1'b1;
			win_cyc <= 1;
		end else if (done) begin
			in_win <= 1'b0;
		end else if (in_win) begin
			win_cyc <= win_cyc + 1;
		end
	end

	// idle is left only on lcd_enable
	idle_stays: assert property (@(posedge clk) disable iff (!arst_n)
		state == ST_IDLE && !lcd_enable |=> state == ST_IDLE)
		else begin
			$error("sequencer left idle without lcd_enable");
			fail_cnt++;
		end

	// the whole strobe window from issue to done sits inside busy
	strobe_in_busy: assert property (@(posedge clk) disable iff (!arst_n)
		issue || in_win |-> busy)
		else begin
			$error("strobe window active while busy is low");
			fail_cnt++;
		end

	// last init step and host transfers issue nothing further
	no_extra_issue: assert property (@(posedge clk) disable iff (!arst_n)
		state == ST_ENTRY || state == ST_XFER |=> !issue)
		else begin
			$error("issue outside idle or an init step");
			fail_cnt++;
		end

	// host window length follows the request class
	xfer_hold: assert property (@(posedge clk) disable iff (!arst_n)
		state == ST_XFER && done |-> win_cyc == clk_per_us *
			((xfer_class == CMD_CLEAR || xfer_class == CMD_HOME) ? T_CLEAR_US : T_SHORT_US))
		else begin
			$error("host transfer window does not match its request class");
			fail_cnt++;
		end

endmodule

bind lcd_sequencer lcd_ctrl_chk #(
	.clk_per_us (clk_per_us)
) u_chk (
	.clk        (clk),
	.arst_n     (arst_n),
	.state      (state),
	.lcd_enable (lcd_enable),
	.issue      (issue),
	.done       (done),
	.busy       (busy),
	.xfer_class (xfer_class)
);

// File: testbench/lcd_monitor.sv
`timescale 1ns/100ps

module lcd_monitor import lcd_pkg::*; #(
	parameter int clk_per_us = 10
) (
	input logic       clk,
	input logic       arst_n,
	input logic       e,
	input logic       rs,
	input logic       rw,
	input logic [7:0] lcd_data,
	input logic       busy
);

	lcd_cmd_t exp_q[$];      // commands still to show up, in issue order
	int       busy_q[$];     // busy lengths still to show up, in cycles
	int       err_cnt   = 0;
	int       pulse_cnt = 0;
	int       e_len     = 0; // cycles of the current e pulse
	int       busy_len  = 0;

	task automatic push_cmd(input lcd_cmd_t c);
		exp_q.push_back(c);
	endtask

	task automatic push_busy(input int n);
		busy_q.push_back(n);
	endtask

	function automatic int pending();
		return exp_q.size() + busy_q.size();
	endfunction

	task automatic check_pulse();
		lcd_cmd_t x;
		pulse_cnt++;
		if (e_len != T_PULSE_US * clk_per_us) begin
			$display("Mismatch at %0t: e high for %0d cycles, expected %0d",
				$time, e_len, T_PULSE_US * clk_per_us);
			err_cnt++;
		end
		if (exp_q.size() == 0) begin
			$display("Unexpected e pulse at %0t with no command pending", $time);
			err_cnt++;
		end else begin
			x = exp_q.pop_front();
			if ({rs, rw, lcd_data} != {x.rs, x.rw, x.data}) begin
				$display("Mismatch at %0t: rs=%0b rw=%0b data=%02h, expected rs=%0b rw=%0b data=%02h",
					$time, rs, rw, lcd_data, x.rs, x.rw, x.data);
				err_cnt++;
			end
		end
	endtask

	task automatic check_busy();
		int n;
		if (busy_q.size() == 0) begin
			$display("Busy interval at %0t that no request explains", $time);
			err_cnt++;
		end else begin
			n = busy_q.pop_front();
			if (busy_len != n) begin
				$display("Mismatch at %0t: busy high for %0d cycles, expected %0d",
					$time, busy_len, n);
				err_cnt++;
			end
		end
	endtask

	// mid-cycle sampling, all DUT outputs are settled here
	always @(negedge clk) begin
		if (!arst_n) begin
			e_len    = 0;
			busy_len = 0;
		end else begin
			if (e) begin
				e_len++;
			end else if (e_len > 0) begin // e just fell, bus still holds the command
				check_pulse();
				e_len = 0;
			end
			if (!busy && (e || rs || rw || lcd_data != 8'h00)) begin
				$display("Mismatch at %0t: idle bus e=%0b rs=%0b rw=%0b data=%02h, expected zero",
					$time, e, rs, rw, lcd_data);
				err_cnt++;
			end
			if (busy) begin
				busy_len++;
			end else if (busy_len > 0) begin
				check_busy();
				busy_len = 0;
			end
		end
	end

endmodule

// File: hdl/lcd_ctrl.sv
`timescale 1ns/100ps

module lcd_ctrl import lcd_pkg::*; #(
	parameter int clk_per_us = 10
) (
	input  logic       clk,
	input  logic       arst_n,
	input  lcd_cfg_t   cfg,
	input  logic       lcd_enable,
	input  lcd_req_t   lcd_bus,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	lcd_cmd_e cmd_class;
	lcd_cmd_t req_cmd; // host request with its hold
	lcd_cmd_t cmd;     // command being issued
	logic     issue;
	logic     done;

	lcd_cmd_decode u_decode (
		.req       (lcd_bus),
		.cmd_class (cmd_class),
		.req_cmd   (req_cmd)
	);

	lcd_sequencer #(
		.clk_per_us (clk_per_us)
	) u_seq (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg        (cfg),
		.lcd_enable (lcd_enable),
		.req_cmd    (req_cmd),
		.cmd_class  (cmd_class),
		.done       (done),
		.issue      (issue),
		.cmd        (cmd),
		.busy       (busy)
	);

	lcd_strobe_gen #(
		.clk_per_us (clk_per_us)
	) u_strobe (
		.clk      (clk),
		.arst_n   (arst_n),
		.issue    (issue),
		.cmd      (cmd),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data),
		.done     (done)
	);

endmodule

// File: hdl/lcd_strobe_gen.sv
`timescale 1ns/100ps

module lcd_strobe_gen import lcd_pkg::*; #(
	parameter int clk_per_us = 10
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       issue,
	input  lcd_cmd_t   cmd,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       done
);

	localparam int CW    = $clog2(512 * clk_per_us + 1); // fits the largest hold
	localparam int E_ON  = 1 + T_SETUP_US * clk_per_us;
	localparam int E_OFF = (T_SETUP_US + T_PULSE_US) * clk_per_us;

	logic          active;   // inside a command window
	logic [CW-1:0] cnt;      // cycles since issue
	logic [CW-1:0] cnt_nxt;
	logic [CW-1:0] hold_cyc; // window length in cycles
	logic          e_nxt;

	always_comb begin
		cnt_nxt = issue ? CW'(1) : cnt + 1'b1;
		e_nxt   = (cnt_nxt >= CW'(E_ON)) && (cnt_nxt <= CW'(E_OFF));
	end

	assign done = active && (cnt == hold_cyc); // last cycle of the hold

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active   <= 1'b0;
			cnt      <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
		end else if (issue) begin
			active   <= 1'b1;
			cnt      <= cnt_nxt;
			e        <= e_nxt;
			rs       <= cmd.rs;
			rw       <= cmd.rw;
			lcd_data <= cmd.data;
		end else if (done) begin
			active   <= 1'b0; // bus back to zero
			cnt      <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
		end else if (active) begin
			cnt <= cnt_nxt;
			e   <= e_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			hold_cyc <= CW'(cmd.hold_us * clk_per_us);
	end

endmodule

// File: hdl/lcd_sequencer.sv
`timescale 1ns/100ps

module lcd_sequencer import lcd_pkg::*; #(
	parameter int clk_per_us = 10
) (
	input  logic     clk,
	input  logic     arst_n,
	input  lcd_cfg_t cfg,
	input  logic     lcd_enable,
	input  lcd_cmd_t req_cmd,
	input  lcd_cmd_e cmd_class,
	input  logic     done,
	output logic     issue,
	output lcd_cmd_t cmd,
	output logic     busy
);

	localparam int P_CYC = T_POWER_US * clk_per_us;
	localparam int PW    = $clog2(P_CYC);

	seq_state_e    state;
	seq_state_e    state_nxt;
	logic [PW-1:0] pcnt;       // power-up wait counter
	logic          issue_nxt;
	lcd_cmd_t      cmd_nxt;
	lcd_cmd_e      xfer_class; // class of the accepted host request

	// init command for the step about to start
	function automatic lcd_cmd_t init_cmd(input seq_state_e st, input lcd_cfg_t c);
		lcd_cmd_t r;
		r.rs = 1'b0;
		r.rw = 1'b0;
		case (st)
			ST_FUNC: begin
				r.data    = {4'b0011, c.lines, c.font, 2'b00};
				r.hold_us = 9'(T_SHORT_US);
			end
			ST_DISP: begin
				r.data    = {5'b00001, c.display, c.cursor, c.blink};
				r.hold_us = 9'(T_SHORT_US);
			end
			ST_CLEAR: begin
				r.data    = 8'b0000_0001;
				r.hold_us = 9'(T_CLEAR_US);
			end
			default: begin // entry mode set
				r.data    = {6'b000001, c.inc_dec, c.shift};
				r.hold_us = 9'(T_ENTRY_US);
			end
		endcase
		return r;
	endfunction

	always_comb begin
		state_nxt = state;
		issue_nxt = 1'b0;
		cmd_nxt   = req_cmd;
		case (state)
			ST_POWER: begin
				if (pcnt == PW'(P_CYC - 1)) begin
					state_nxt = ST_FUNC;
					issue_nxt = 1'b1;
				end
			end
			ST_FUNC: begin
				if (done) begin
					state_nxt = ST_DISP;
					issue_nxt = 1'b1;
				end
			end
			ST_DISP: begin
				if (done) begin
					state_nxt = ST_CLEAR;
					issue_nxt = 1'b1;
				end
			end
			ST_CLEAR: begin
				if (done) begin
					state_nxt = ST_ENTRY;
					issue_nxt = 1'b1;
				end
			end
			ST_ENTRY: begin
				if (done)
					state_nxt = ST_IDLE; // init complete
			end
			ST_IDLE: begin
				if (lcd_enable) begin // level, sampled only here
					state_nxt = ST_XFER;
					issue_nxt = 1'b1;
				end
			end
			ST_XFER: begin
				if (done)
					state_nxt = ST_IDLE;
			end
			default: state_nxt = ST_POWER;
		endcase
		if (state_nxt != ST_XFER)
			cmd_nxt = init_cmd(state_nxt, cfg);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_POWER;
			pcnt  <= '0;
			issue <= 1'b0;
			busy  <= 1'b1;
		end else begin
			state <= state_nxt;
			issue <= issue_nxt;
			busy  <= (state_nxt != ST_IDLE); // falls the cycle after done
			if (state == ST_POWER)
				pcnt <= pcnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_nxt)
			cmd <= cmd_nxt;
		if (state == ST_IDLE && lcd_enable)
			xfer_class <= cmd_class;
	end

endmodule

// File: hdl/lcd_cmd_decode.sv
`timescale 1ns/100ps

module lcd_cmd_decode import lcd_pkg::*; (
	input  lcd_req_t req,
	output lcd_cmd_e cmd_class,
	output lcd_cmd_t req_cmd
);

	// instruction class from rs, rw and the leading one of data
	always_comb begin
		if (req.rw) begin
			cmd_class = CMD_READ; // busy flag/address or data read
		end else if (req.rs) begin
			cmd_class = CMD_WRITE; // data to ddram or cgram
		end else begin
			casez (req.data)
				8'b1???????: cmd_class = CMD_DDRAM_ADDR;
				8'b01??????: cmd_class = CMD_CGRAM_ADDR;
				8'b001?????: cmd_class = CMD_FUNC;
				8'b0001????: cmd_class = CMD_SHIFT;
				8'b00001???: cmd_class = CMD_DISPLAY;
				8'b000001??: cmd_class = CMD_ENTRY;
				8'b0000001?: cmd_class = CMD_HOME;
				8'b00000001: cmd_class = CMD_CLEAR;
				// 0x00 is no instruction, treated as a short one
				default:     cmd_class = CMD_FUNC;
			endcase
		end
	end

	// the request goes out as is, only the hold is added
	always_comb begin
		req_cmd.rs   = req.rs;
		req_cmd.rw   = req.rw;
		req_cmd.data = req.data;
		if (cmd_class == CMD_CLEAR || cmd_class == CMD_HOME) begin
			req_cmd.hold_us = 9'(T_CLEAR_US); // display needs the long wait
		end else begin
			req_cmd.hold_us = 9'(T_SHORT_US);
		end
	end

endmodule

// File: hdl/lcd_pkg.sv
package lcd_pkg;

	// timing in microseconds, scaled by clk_per_us in the modules
	localparam int T_POWER_US = 500; // power-up wait
	localparam int T_SETUP_US = 1;   // rs/rw/data valid before e rises
	localparam int T_PULSE_US = 13;  // e high width
	localparam int T_SHORT_US = 50;  // ordinary instruction or data
	localparam int T_CLEAR_US = 200; // clear display, return home
	localparam int T_ENTRY_US = 100; // entry mode set during init

	// same bit order as the host bus {rs, rw, data}
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_req_t;

	// power-up configuration word
	typedef struct packed {
		logic lines;   // 1 = two lines
		logic font;    // 1 = 5x10 dots
		logic display; // display on
		logic cursor;  // cursor on
		logic blink;   // cursor blink
		logic inc_dec; // 1 = increment address
		logic shift;   // shift display on write
	} lcd_cfg_t;

	// one command for the strobe generator
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
		logic [8:0] hold_us; // whole window length
	} lcd_cmd_t;

	typedef enum logic [3:0] {
		CMD_CLEAR,
		CMD_HOME,
		CMD_ENTRY,
		CMD_DISPLAY,
		CMD_SHIFT,
		CMD_FUNC,
		CMD_CGRAM_ADDR,
		CMD_DDRAM_ADDR,
		CMD_WRITE,
		CMD_READ
	} lcd_cmd_e;

	typedef enum logic [2:0] {
		ST_POWER,
		ST_FUNC,
		ST_DISP,
		ST_CLEAR,
		ST_ENTRY,
		ST_IDLE,
		ST_XFER
	} seq_state_e;

endpackage
